//--- verif/conv3x3_tests.svh
`ifndef conv3x3_tests_svh
`define conv3x3_tests_svh

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic check_frame_counts(input int seen0, input int lasts0, input int frames);
  if (results_seen - seen0 != frames * window_count) begin
    fail_stop($sformatf("got %0d results, expected %0d",
                        results_seen - seen0, frames * window_count));
  end
  if (lasts_seen - lasts0 != frames) begin
    fail_stop($sformatf("last was set %0d times, expected %0d", lasts_seen - lasts0, frames));
  end
endtask

task automatic idle_after_reset();
  repeat (20) begin
    @(negedge clk);
    if (result_valid !== 1'b0) begin
      fail_stop("result_valid went high with no pixels after reset");
    end
  end
endtask

// identity kernel passes the centre pixel through
task automatic identity_constant_frame();
  conv_pkg::kernel_t k;
  int                seen0;
  int                lasts0;
  k      = '0;
  k.k11  = 8'sd1;
  seen0  = results_seen;
  lasts0 = lasts_seen;
  fill_constant_frame(8'd77);
  drive_frame(k, 0);
  wait_for_drain();
  check_frame_counts(seen0, lasts0, 1);
endtask

task automatic random_frame_back_to_back();
  int seen0;
  int lasts0;
  seen0  = results_seen;
  lasts0 = lasts_seen;
  fill_random_frame();
  frame_kernel = random_kernel();
  drive_frame(frame_kernel, 0);
  wait_for_drain();
  check_frame_counts(seen0, lasts0, 1);
endtask

// reuses the previous random frame and kernel
task automatic random_frame_with_gaps();
  int seen0;
  int lasts0;
  seen0  = results_seen;
  lasts0 = lasts_seen;
  drive_frame(frame_kernel, max_gap);
  wait_for_drain();
  check_frame_counts(seen0, lasts0, 1);
endtask

task automatic two_frames_kernel_change();
  int seen0;
  int lasts0;
  seen0  = results_seen;
  lasts0 = lasts_seen;
  fill_random_frame();
  drive_frame(random_kernel(), 0);
  // second frame follows with no idle cycle
  fill_random_frame();
  drive_frame(random_kernel(), 0);
  wait_for_drain();
  check_frame_counts(seen0, lasts0, 2);
endtask

// 9 * 255 * -128 is the bottom of the acc_t range in use
task automatic most_negative_sum();
  int seen0;
  int lasts0;
  seen0  = results_seen;
  lasts0 = lasts_seen;
  fill_constant_frame(8'd255);
  drive_frame({9{8'h80}}, 0);
  wait_for_drain();
  check_frame_counts(seen0, lasts0, 1);
endtask

`endif

//--- verif/conv3x3_tb.sv
`timescale 1ns/10ps
`default_nettype none

module conv3x3_tb;

  localparam int image_width  = 16;
  localparam int image_height = 8;
  localparam int frame_len    = image_width * image_height;
  localparam int max_gap      = 3;
  localparam int window_count = (image_width - 2) * (image_height - 2);
  // reset, idle check, five plain frames and one frame with worst-case gaps
  localparam int test_len      = 16 + 20 + 5 * frame_len + frame_len * (1 + max_gap);
  localparam int timeout_limit = 2 * test_len + 200;

  logic                   clk;
  logic                   reset;
  logic                   pixel_valid;
  conv_pkg::pixel_t       pixel;
  conv_pkg::kernel_t      kernel;
  logic                   result_valid;
  conv_pkg::conv_result_t result;

  int unsigned            rng_state = 53740;
  int                     cycle = 0;
  int                     results_seen = 0;
  int                     lasts_seen = 0;
  conv_pkg::pixel_t       frame_pix [image_height][image_width];
  conv_pkg::kernel_t      frame_kernel;
  conv_pkg::conv_result_t exp_results [$];
  int                     exp_cycles [$];
  conv_pkg::conv_result_t exp_r;
  int                     exp_c;

  conv3x3_top #(
    .image_width  (image_width),
    .image_height (image_height)
  ) dut (
    .clk          (clk),
    .reset        (reset),
    .pixel_valid  (pixel_valid),
    .pixel        (pixel),
    .kernel       (kernel),
    .result_valid (result_valid),
    .result       (result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  //////////////////////////////////////////////////
  // error reporting and compares
  //////////////////////////////////////////////////

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic compare_result(input string name, input conv_pkg::conv_result_t got,
                                input conv_pkg::conv_result_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("** Error at %0t: %s value=%0d last=%0b, expected value=%0d last=%0b",
                          $time, name, got.value, got.last, exp.value, exp.last));
    end
  endtask

  task automatic compare_cycle(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_stop($sformatf("** Error at %0t: %s seen in cycle %0d, expected cycle %0d",
                          $time, name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  function automatic int unsigned lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state >> 16;
  endfunction

  task automatic fill_constant_frame(input conv_pkg::pixel_t value);
    for (int row = 0; row < image_height; row++) begin
      for (int col = 0; col < image_width; col++) begin
        frame_pix[row][col] = value;
      end
    end
  endtask

  task automatic fill_random_frame();
    for (int row = 0; row < image_height; row++) begin
      for (int col = 0; col < image_width; col++) begin
        frame_pix[row][col] = conv_pkg::pixel_t'(lcg_next());
      end
    end
  endtask

  function automatic conv_pkg::kernel_t random_kernel();
    conv_pkg::kernel_t k;
    k = '0;
    // shift in nine random weights
    for (int i = 0; i < 9; i++) begin
      k = {k[63:0], 8'(lcg_next())};
    end
    return k;
  endfunction

  //////////////////////////////////////////////////
  // golden model
  //////////////////////////////////////////////////

  // weight at window row dr, column dc, both counted from the oldest
  function automatic int coef_at(input conv_pkg::kernel_t k, input int dr, input int dc);
    case (dr * 3 + dc)
      0: return int'(k.k00);
      1: return int'(k.k01);
      2: return int'(k.k02);
      3: return int'(k.k10);
      4: return int'(k.k11);
      5: return int'(k.k12);
      6: return int'(k.k20);
      7: return int'(k.k21);
      default: return int'(k.k22);
    endcase
  endfunction

  task automatic compute_expected(input conv_pkg::kernel_t k);
    int sum;
    conv_pkg::conv_result_t r;
    for (int row = 2; row < image_height; row++) begin
      for (int col = 2; col < image_width; col++) begin
        sum = 0;
        for (int dr = 0; dr < 3; dr++) begin
          for (int dc = 0; dc < 3; dc++) begin
            sum += int'(frame_pix[row-2+dr][col-2+dc]) * coef_at(k, dr, dc);
          end
        end
        r.value = conv_pkg::acc_t'(sum);
        r.last  = (row == image_height - 1) && (col == image_width - 1);
        exp_results.push_back(r);
      end
    end
  endtask

  // streams frame_pix in raster order, gaps of 0 to gap_max idle cycles
  task automatic drive_frame(input conv_pkg::kernel_t k, input int gap_max);
    int gap;
    compute_expected(k);
    for (int row = 0; row < image_height; row++) begin
      for (int col = 0; col < image_width; col++) begin
        if (gap_max > 0 && (row != 0 || col != 0)) begin
          gap = lcg_next() % (gap_max + 1);
          repeat (gap) begin
            @(negedge clk);
            pixel_valid = 1'b0;
          end
        end
        @(negedge clk);
        pixel_valid = 1'b1;
        pixel       = frame_pix[row][col];
        // previous frame's last window is weighted by now
        if (row == 0 && col == 1) begin
          kernel = k;
        end
        if (row >= 2 && col >= 2) begin
          exp_cycles.push_back(cycle + 2);
        end
      end
    end
  endtask

  task automatic wait_for_drain();
    int waited;
    @(negedge clk);
    pixel_valid = 1'b0;
    waited = 0;
    while (exp_results.size() != 0 && waited < 8) begin
      @(posedge clk);
      waited++;
    end
    if (exp_results.size() != 0 || exp_cycles.size() != 0) begin
      fail_stop($sformatf("%0d expected results never arrived", exp_results.size()));
    end
  endtask

  //////////////////////////////////////////////////
  // monitor and timeout
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!reset && result_valid) begin
      if (exp_results.size() == 0 || exp_cycles.size() == 0) begin
        fail_stop("result_valid was high while no result was expected");
      end else begin
        exp_r = exp_results.pop_front();
        exp_c = exp_cycles.pop_front();
        compare_result("result", result, exp_r);
        compare_cycle("result_valid", cycle, exp_c);
        results_seen++;
        if (result.last) begin
          lasts_seen++;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (cycle >= timeout_limit) begin
      fail_stop($sformatf("timeout, run still going after %0d cycles", cycle));
    end
  end

  initial begin
    reset       = 1'b1;
    pixel_valid = 1'b0;
    pixel       = '0;
    kernel      = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    idle_after_reset();
    identity_constant_frame();
    random_frame_back_to_back();
    random_frame_with_gaps();
    two_frames_kernel_change();
    most_negative_sum();
    if (exp_results.size() == 0 && exp_cycles.size() == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      fail_stop("expected results left over at the end of the run");
    end
  end

  `include "conv3x3_tests.svh"

endmodule

`default_nettype wire

//--- verilog/conv3x3_top.sv
`timescale 1ns/10ps
`default_nettype none

module conv3x3_top #(
  parameter int unsigned image_width  = 16,
  parameter int unsigned image_height = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   pixel_valid,
  input  conv_pkg::pixel_t       pixel,
  input  conv_pkg::kernel_t      kernel,
  output logic                   result_valid,
  output conv_pkg::conv_result_t result
);

  //////////////////////////////////////////////////
  // internal nets
  //////////////////////////////////////////////////

  conv_pkg::window_t window;
  logic              window_ok;
  logic              window_last;

  //////////////////////////////////////////////////
  // window path and position tracking, side by side
  //////////////////////////////////////////////////

  window_gen #(
    .image_width (image_width)
  ) u_window_gen (
    .clk         (clk),
    .reset       (reset),
    .pixel_valid (pixel_valid),
    .pixel       (pixel),
    .window      (window)
  );

  // flags line up with the registered window
  frame_tracker #(
    .image_width  (image_width),
    .image_height (image_height)
  ) u_frame_tracker (
    .clk         (clk),
    .reset       (reset),
    .pixel_valid (pixel_valid),
    .window_ok   (window_ok),
    .window_last (window_last)
  );

  //////////////////////////////////////////////////
  // weighted sum
  //////////////////////////////////////////////////

  // result two cycles after the completing strobe
  conv_mac u_conv_mac (
    .clk          (clk),
    .reset        (reset),
    .window_ok    (window_ok),
    .window_last  (window_last),
    .window       (window),
    .kernel       (kernel),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

//--- verilog/conv_mac.sv
`timescale 1ns/10ps
`default_nettype none

module conv_mac (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   window_ok,
  input  logic                   window_last,
  input  conv_pkg::window_t      window,
  input  conv_pkg::kernel_t      kernel,
  output logic                   result_valid,
  output conv_pkg::conv_result_t result
);

  //////////////////////////////////////////////////
  // multiply and sum
  //////////////////////////////////////////////////

  conv_pkg::pixel_t pix_tap  [conv_pkg::num_taps];
  conv_pkg::coef_t  coef_tap [conv_pkg::num_taps];
  conv_pkg::acc_t   sum;

  // window and kernel share the same packed layout,
  // so equal slices pair each pixel with its weight
  always_comb begin
    for (int i = 0; i < conv_pkg::num_taps; i++) begin
      pix_tap[i]  = window[i*conv_pkg::pixel_width +: conv_pkg::pixel_width];
      coef_tap[i] = kernel[i*conv_pkg::coef_width +: conv_pkg::coef_width];
    end
  end

  always_comb begin
    conv_pkg::acc_t pix_ext;
    conv_pkg::acc_t coef_ext;
    sum = '0;
    for (int i = 0; i < conv_pkg::num_taps; i++) begin
      // zero-extend pixel, sign-extend weight
      pix_ext  = conv_pkg::acc_t'({1'b0, pix_tap[i]});
      coef_ext = conv_pkg::acc_t'(coef_tap[i]);
      sum      = sum + pix_ext * coef_ext;
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= window_ok;
    end
  end

  // payload only loads on a complete window
  always_ff @(posedge clk) begin
    if (window_ok) begin
      result.value <= sum;
      result.last  <= window_last;
    end
  end

  a_valid_known : assert property (@(posedge clk)
    !reset |-> !$isunknown(result_valid));

endmodule

`default_nettype wire

//--- verilog/conv_pkg.sv
`default_nettype none

package conv_pkg;

  //////////////////////////////////////////////////
  // sample and weight types
  //////////////////////////////////////////////////

  localparam int unsigned pixel_width = 8;
  localparam int unsigned coef_width  = 8;
  localparam int unsigned acc_width   = 20;
  localparam int unsigned num_taps    = 9;

  // unsigned image sample
  typedef logic [pixel_width-1:0] pixel_t;

  // signed kernel weight
  typedef logic signed [coef_width-1:0] coef_t;

  // 9 * 255 * 128 plus sign fits in 20 bits
  typedef logic signed [acc_width-1:0] acc_t;

  //////////////////////////////////////////////////
  // 3x3 groupings, row-major, 00 is oldest
  //////////////////////////////////////////////////

  typedef struct packed {
    coef_t k00;
    coef_t k01;
    coef_t k02;
    coef_t k10;
    coef_t k11;
    coef_t k12;
    coef_t k20;
    coef_t k21;
    coef_t k22;
  } kernel_t;

  // p22 is the newest pixel
  typedef struct packed {
    pixel_t p00;
    pixel_t p01;
    pixel_t p02;
    pixel_t p10;
    pixel_t p11;
    pixel_t p12;
    pixel_t p20;
    pixel_t p21;
    pixel_t p22;
  } window_t;

  // one output sample plus end of frame marker
  typedef struct packed {
    acc_t value;
    logic last;
  } conv_result_t;

endpackage

`default_nettype wire

//--- verilog/frame_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module frame_tracker #(
  parameter int unsigned image_width  = 16,
  parameter int unsigned image_height = 8
) (
  input  logic clk,
  input  logic reset,
  input  logic pixel_valid,
  output logic window_ok,
  output logic window_last
);

  localparam int unsigned col_w = $clog2(image_width);
  localparam int unsigned row_w = $clog2(image_height);

  //////////////////////////////////////////////////
  // position of the pixel being accepted
  //////////////////////////////////////////////////

  logic [col_w-1:0] col_cnt;
  logic [row_w-1:0] row_cnt;
  logic             end_of_row;
  logic             end_of_frame;

  assign end_of_row   = (col_cnt == col_w'(image_width - 1));
  assign end_of_frame = end_of_row && (row_cnt == row_w'(image_height - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (pixel_valid) begin
      if (end_of_row) begin
        col_cnt <= '0;
        // wrap to row 0 after the last pixel of the frame
        row_cnt <= end_of_frame ? '0 : row_cnt + 1'b1;
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // window flags
  //////////////////////////////////////////////////

  // registered alongside the window update, one cycle pulses
  always_ff @(posedge clk) begin
    if (reset) begin
      window_ok   <= 1'b0;
      window_last <= 1'b0;
    end else begin
      window_ok   <= pixel_valid && (row_cnt >= 2) && (col_cnt >= 2);
      window_last <= pixel_valid && end_of_frame;
    end
  end

  // counters never leave the image
  a_col_range : assert property (@(posedge clk) disable iff (reset)
    col_cnt < image_width);
  a_row_range : assert property (@(posedge clk) disable iff (reset)
    row_cnt < image_height);

  // last window is always a complete one
  a_last_ok : assert property (@(posedge clk) disable iff (reset)
    $rose(window_last) |-> window_ok);

endmodule

`default_nettype wire

//--- verilog/line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module line_buffer #(
  parameter int unsigned image_width = 16
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             shift,
  input  conv_pkg::pixel_t din,
  output conv_pkg::pixel_t dout
);

  //////////////////////////////////////////////////
  // row storage
  //////////////////////////////////////////////////

  // mem[0] is the newest accepted pixel
  conv_pkg::pixel_t mem [image_width];

  // advances only on an accepted pixel, so idle cycles
  // between strobes leave the row alignment intact
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < image_width; i++) begin
        mem[i] <= '0;
      end
    end else if (shift) begin
      mem[0] <= din;
      for (int i = 1; i < image_width; i++) begin
        mem[i] <= mem[i-1];
      end
    end
  end

  //////////////////////////////////////////////////
  // output tap
  //////////////////////////////////////////////////

  // pixel accepted image_width strobes ago,
  // i.e. same column one row up when din arrives
  assign dout = mem[image_width-1];

endmodule

`default_nettype wire

//--- verilog/window_gen.sv
`timescale 1ns/10ps
`default_nettype none

module window_gen #(
  parameter int unsigned image_width = 16
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              pixel_valid,
  input  conv_pkg::pixel_t  pixel,
  output conv_pkg::window_t window
);

  //////////////////////////////////////////////////
  // row delays
  //////////////////////////////////////////////////

  conv_pkg::pixel_t row_up_1;
  conv_pkg::pixel_t row_up_2;

  // one row above the incoming pixel
  line_buffer #(
    .image_width (image_width)
  ) row_buf_1 (
    .clk   (clk),
    .reset (reset),
    .shift (pixel_valid),
    .din   (pixel),
    .dout  (row_up_1)
  );

  // two rows above, chained off the first buffer
  line_buffer #(
    .image_width (image_width)
  ) row_buf_2 (
    .clk   (clk),
    .reset (reset),
    .shift (pixel_valid),
    .din   (row_up_1),
    .dout  (row_up_2)
  );

  //////////////////////////////////////////////////
  // column shift registers
  //////////////////////////////////////////////////

  // index 0 is oldest row / oldest column, matching window_t
  conv_pkg::pixel_t col_in [3];
  conv_pkg::pixel_t taps   [3][3];

  assign col_in[0] = row_up_2;
  assign col_in[1] = row_up_1;
  assign col_in[2] = pixel;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < 3; r++) begin
        for (int c = 0; c < 3; c++) begin
          taps[r][c] <= '0;
        end
      end
    end else if (pixel_valid) begin
      for (int r = 0; r < 3; r++) begin
        taps[r][0] <= taps[r][1];
        taps[r][1] <= taps[r][2];
        taps[r][2] <= col_in[r];
      end
    end
  end

  //////////////////////////////////////////////////
  // window output
  //////////////////////////////////////////////////

  // row edges are not checked here, frame_tracker
  // decides whether the window is usable
  assign window.p00 = taps[0][0];
  assign window.p01 = taps[0][1];
  assign window.p02 = taps[0][2];
  assign window.p10 = taps[1][0];
  assign window.p11 = taps[1][1];
  assign window.p12 = taps[1][2];
  assign window.p20 = taps[2][0];
  assign window.p21 = taps[2][1];
  assign window.p22 = taps[2][2];

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verif
verilog/conv_pkg.sv
verilog/line_buffer.sv
verilog/window_gen.sv
verilog/frame_tracker.sv
verilog/conv_mac.sv
verilog/conv3x3_top.sv
verif/conv3x3_tb.sv
